// ==== lsu_top.f ====
hdl/lsu_pkg.sv
hdl/lsu_align.sv
hdl/lsu_port_fsm.sv
hdl/lsu_region_cfg.sv
hdl/mem_backend.sv
hdl/lsu_top.sv
bench/lsu_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsu_top_tb -f lsu_top.f

out=$(./obj_dir/Vlsu_top_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "^All tests passed$"; then
    exit 0
fi
exit 1

// ==== bench/lsu_top_tb.sv ====
`timescale 1ns/1ps

module lsu_top_tb;

    import lsu_pkg::*;

    localparam int RAND_OPS   = 400;
    // Worst case is about nine cycles per random access plus the directed part
    localparam int MAX_CYCLES = RAND_OPS * 15;

    logic     clk_i;
    logic     rstn_i;
    logic     req_valid_i;
    lsu_req_t req_i;
    logic     ready_o;
    logic     resp_valid_o;
    word_t    resp_data_o;
    logic     cfg_we_i;
    logic     cfg_sel_i;
    addr_t    cfg_wdata_i;

    // Byte-wide reference copies of RAM window and I/O bank
    logic [7:0] ram_model [1024];
    logic [7:0] io_model [16];
    addr_t      base_m;
    addr_t      mask_m;
    int         cycle_cnt = 0;
    integer     seed;

    lsu_top dut (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .ready_o      (ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o),
        .cfg_we_i     (cfg_we_i),
        .cfg_sel_i    (cfg_sel_i),
        .cfg_wdata_i  (cfg_wdata_i)
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic fail_check(input string msg);
        $display("MISMATCH at time %0t: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic logic is_uncached(input addr_t a);
        return (a & ~mask_m) != base_m;
    endfunction

    function automatic word_t expected_load(input addr_t a, input size_t s);
        word_t      raw;
        logic [9:0] ri;
        logic [3:0] ii;
        logic       unc;
        unc = is_uncached(a);
        ri = a[9:0];
        ii = a[3:0];
        // Little endian, byte at the address lands in bits 7:0
        for (int i = 0; i < 4; i++) begin
            raw[8*i +: 8] = unc ? io_model[ii] : ram_model[ri];
            ri = ri + 10'd1;
            ii = ii + 4'd1;
        end
        case (s)
            SIZE_B:  return {{24{raw[7]}}, raw[7:0]};
            SIZE_BU: return {24'h00_0000, raw[7:0]};
            SIZE_H:  return {{16{raw[15]}}, raw[15:0]};
            SIZE_HU: return {16'h0000, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    task automatic model_store(input addr_t a, input size_t s, input word_t d);
        int         n;
        logic [9:0] ri;
        logic [3:0] ii;
        logic       unc;
        unc = is_uncached(a);
        n = (s == SIZE_W) ? 4 : ((s == SIZE_H) ? 2 : 1);
        ri = a[9:0];
        ii = a[3:0];
        for (int i = 0; i < n; i++) begin
            if (unc) begin
                io_model[ii] = d[8*i +: 8];
            end else begin
                ram_model[ri] = d[8*i +: 8];
            end
            ri = ri + 10'd1;
            ii = ii + 4'd1;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk_i);
        #1;
    endtask

    task automatic write_cfg(input logic sel, input addr_t val);
        cfg_we_i    = 1'b1;
        cfg_sel_i   = sel;
        cfg_wdata_i = val;
        if (sel) begin
            mask_m = val;
        end else begin
            base_m = val;
        end
        @(posedge clk_i);
        #1;
        cfg_we_i = 1'b0;
    endtask

    // One request from the core, checked for latency, data and ready_o
    task automatic do_access(input logic wr, input size_t sz, input addr_t a, input word_t wd);
        int    exp_lat;
        int    lat;
        word_t got;
        word_t exp_data;
        exp_lat  = (wr ? 1 : 2) + (is_uncached(a) ? IO_WAIT : 0);
        exp_data = wr ? 32'h0 : expected_load(a, sz);
        req_i.write = wr;
        req_i.size  = sz;
        req_i.addr  = a;
        req_i.wdata = wd;
        req_valid_i = 1'b1;
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b0;
        lat = 1;
        @(negedge clk_i);
        while (!resp_valid_o) begin
            assert (!ready_o) else fail_check("ready_o high while an access is pending");
            lat++;
            @(negedge clk_i);
        end
        got = resp_data_o;
        assert (!ready_o) else fail_check("ready_o high in the response cycle");
        assert (lat == exp_lat) else fail_check($sformatf(
            "addr 0x%08h write %0b latency %0d, expected %0d", a, wr, lat, exp_lat));
        assert (got == exp_data) else fail_check($sformatf(
            "addr 0x%08h size %0d data 0x%08h, expected 0x%08h", a, sz, got, exp_data));
        if (wr) begin
            model_store(a, sz, wd);
        end
        @(posedge clk_i);
        #1;
        assert (ready_o) else fail_check("ready_o not high after the response");
    endtask

    initial begin
        logic [31:0] r;
        word_t       wd;
        addr_t       a;
        logic        wr;
        size_t       sz;
        logic [1:0]  off;
        int          sel;

        clk_i       = 1'b0;
        rstn_i      = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        cfg_we_i    = 1'b0;
        cfg_sel_i   = 1'b0;
        cfg_wdata_i = '0;
        base_m      = REGION_BASE_RST;
        mask_m      = REGION_MASK_RST;
        ram_model   = '{default: 8'h00};
        io_model    = '{default: 8'h00};
        seed        = 3317;

        repeat (16) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        assert (ready_o && !resp_valid_o) else fail_check("ready_o or resp_valid_o wrong after reset");

        // Known contents for the 16 RAM words used below
        for (int k = 0; k < 16; k++) begin
            a = addr_t'(k * 68);
            do_access(1'b1, SIZE_W, a, (a * 32'h9E37_79B9) ^ 32'h5A5A_A5A5);
        end

        for (int k = 4; k < 8; k++) begin
            do_access(1'b1, SIZE_W, addr_t'(k * 68), 32'hDEAD_0000 ^ (k * 32'h0101_0101));
        end
        for (int k = 4; k < 8; k++) begin
            do_access(1'b0, SIZE_W, addr_t'(k * 68), '0);
        end

        // Byte lanes, some with the sign bit set
        for (int off_i = 0; off_i < 4; off_i++) begin
            do_access(1'b1, SIZE_B, 32'h88 + off_i, 32'h1234_5670 + off_i * 137);
        end
        for (int off_i = 0; off_i < 4; off_i++) begin
            do_access(1'b0, SIZE_B, 32'h88 + off_i, '0);
            do_access(1'b0, SIZE_BU, 32'h88 + off_i, '0);
        end
        for (int off_i = 0; off_i < 4; off_i += 2) begin
            do_access(1'b1, SIZE_H, 32'hCC + off_i, 32'h0000_7F01 + off_i * 32'h4000);
            do_access(1'b0, SIZE_H, 32'hCC + off_i, '0);
            do_access(1'b0, SIZE_HU, 32'hCC + off_i, '0);
        end
        do_access(1'b0, SIZE_W, 32'h88, '0);
        do_access(1'b0, SIZE_W, 32'hCC, '0);

        // I/O bank, read back through far aliases
        for (int i = 0; i < 4; i++) begin
            do_access(1'b1, SIZE_W, 32'h0000_1000 + i * 4, 32'hCAFE_8000 + i);
        end
        for (int i = 0; i < 4; i++) begin
            do_access(1'b0, SIZE_W, 32'h8000_0000 + i * 4, '0);
        end
        do_access(1'b1, SIZE_B, 32'h0004_0006, 32'h0000_00A5);
        do_access(1'b0, SIZE_B, 32'h7000_0006, '0);
        do_access(1'b0, SIZE_HU, 32'h0000_0406, '0);

        // Window moved to 0x2000
        write_cfg(1'b0, 32'h0000_2000);
        do_access(1'b0, SIZE_W, 32'h0000_0044, '0);
        do_access(1'b0, SIZE_W, 32'h0000_2044, '0);
        do_access(1'b1, SIZE_W, 32'h0000_2048, 32'h600D_F00D);
        do_access(1'b0, SIZE_W, 32'h0000_2048, '0);
        do_access(1'b1, SIZE_B, 32'h0000_0049, 32'h0000_005E);
        do_access(1'b0, SIZE_BU, 32'h0000_0049, '0);

        // 4 KB window at zero
        write_cfg(1'b0, 32'h0000_0000);
        write_cfg(1'b1, 32'h0000_0FFF);
        do_access(1'b0, SIZE_W, 32'h0000_0848, '0);
        do_access(1'b0, SIZE_W, 32'h0000_1048, '0);
        write_cfg(1'b1, REGION_MASK_RST);

        for (int n = 0; n < RAND_OPS; n++) begin
            r   = $random(seed);
            wd  = $random(seed);
            off = r[1:0];
            wr  = r[8];
            sel = r[11:9] % (wr ? 3 : 5);
            case (sel)
                0:       sz = SIZE_B;
                1:       sz = SIZE_H;
                2:       sz = SIZE_W;
                3:       sz = SIZE_BU;
                default: sz = SIZE_HU;
            endcase
            if (sz == SIZE_W) begin
                off = 2'b00;
            end else if (sz == SIZE_H || sz == SIZE_HU) begin
                off[0] = 1'b0;
            end
            if (r[12]) begin
                a = {1'b1, r[31:17], 12'h000, r[14:13], off};
            end else begin
                a = {22'h0, r[7:4], r[7:4], off};
            end
            idle_cycles(1 + r[3:2] % 3);
            do_access(wr, sz, a, wd);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== hdl/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              req_valid_i,
    input  lsu_pkg::lsu_req_t req_i,
    output logic              ready_o,
    output logic              resp_valid_o,
    output lsu_pkg::word_t    resp_data_o,
    input  logic              cfg_we_i,
    input  logic              cfg_sel_i,
    input  lsu_pkg::addr_t    cfg_wdata_i
);

    import lsu_pkg::*;

    logic     uncached;
    mem_req_t port_req;
    logic     port_valid;
    logic     port_ready;
    word_t    port_rdata;
    logic     port_rvalid;
    logic     port_rready;

    lsu_region_cfg u_region_cfg (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_sel_i   (cfg_sel_i),
        .cfg_wdata_i (cfg_wdata_i),
        .addr_i      (req_i.addr),
        .uncached_o  (uncached)
    );

    lsu_port_fsm u_port_fsm (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .uncached_i    (uncached),
        .port_ready_i  (port_ready),
        .port_rdata_i  (port_rdata),
        .port_rvalid_i (port_rvalid),
        .ready_o       (ready_o),
        .resp_valid_o  (resp_valid_o),
        .resp_data_o   (resp_data_o),
        .port_req_o    (port_req),
        .port_valid_o  (port_valid),
        .port_rready_o (port_rready)
    );

    mem_backend u_mem_backend (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .port_req_i    (port_req),
        .port_valid_i  (port_valid),
        .port_rready_i (port_rready),
        .port_ready_o  (port_ready),
        .port_rdata_o  (port_rdata),
        .port_rvalid_o (port_rvalid)
    );

endmodule

// ==== hdl/mem_backend.sv ====
`timescale 1ns/1ps

module mem_backend (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  lsu_pkg::mem_req_t port_req_i,
    input  logic              port_valid_i,
    input  logic              port_rready_i,
    output logic              port_ready_o,
    output lsu_pkg::word_t    port_rdata_o,
    output logic              port_rvalid_o
);

    import lsu_pkg::*;

    word_t                 ram [RAM_WORDS];
    word_t                 io_regs [IO_WORDS];

    logic [RAM_IDX_W-1:0]  ram_idx;
    logic [IO_IDX_W-1:0]   io_idx;
    logic [WAIT_CNT_W-1:0] wait_cnt_r;
    logic                  xfer;
    word_t                 rdata_r;
    logic                  rvalid_r;

    assign ram_idx = port_req_i.addr[RAM_IDX_W+1:2];
    assign io_idx  = port_req_i.addr[IO_IDX_W+1:2];

    // I/O side answers only after the wait states
    assign port_ready_o = !port_req_i.uncached || (wait_cnt_r == WAIT_CNT_W'(IO_WAIT));
    assign xfer         = port_valid_i && port_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wait_cnt_r <= '0;
        end else if (xfer) begin
            wait_cnt_r <= '0;
        end else if (port_valid_i && port_req_i.uncached) begin
            wait_cnt_r <= wait_cnt_r + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer && port_req_i.write && !port_req_i.uncached) begin
            for (int b = 0; b < 4; b++) begin
                if (port_req_i.mask[b]) begin
                    ram[ram_idx][8*b +: 8] <= port_req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < IO_WORDS; i++) begin
                io_regs[i] <= '0;
            end
        end else if (xfer && port_req_i.write && port_req_i.uncached) begin
            for (int b = 0; b < 4; b++) begin
                if (port_req_i.mask[b]) begin
                    io_regs[io_idx][8*b +: 8] <= port_req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // Read word held until the port unit takes it
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rvalid_r <= 1'b0;
        end else if (xfer && !port_req_i.write) begin
            rvalid_r <= 1'b1;
        end else if (rvalid_r && port_rready_i) begin
            rvalid_r <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer && !port_req_i.write) begin
            rdata_r <= port_req_i.uncached ? io_regs[io_idx] : ram[ram_idx];
        end
    end

    assign port_rdata_o  = rdata_r;
    assign port_rvalid_o = rvalid_r;

endmodule

// ==== hdl/lsu_region_cfg.sv ====
`timescale 1ns/1ps

module lsu_region_cfg (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic           cfg_we_i,
    input  logic           cfg_sel_i,
    input  lsu_pkg::addr_t cfg_wdata_i,
    input  lsu_pkg::addr_t addr_i,
    output logic           uncached_o
);

    import lsu_pkg::*;

    addr_t base_r;
    addr_t mask_r;

    // Select 0 writes the base, 1 the mask
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            base_r <= REGION_BASE_RST;
            mask_r <= REGION_MASK_RST;
        end else if (cfg_we_i) begin
            if (cfg_sel_i) begin
                mask_r <= cfg_wdata_i;
            end else begin
                base_r <= cfg_wdata_i;
            end
        end
    end

    // Outside the cacheable window
    assign uncached_o = (addr_i & ~mask_r) != base_r;

endmodule

// ==== hdl/lsu_port_fsm.sv ====
`timescale 1ns/1ps

module lsu_port_fsm (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               req_valid_i,
    input  lsu_pkg::lsu_req_t  req_i,
    input  logic               uncached_i,
    input  logic               port_ready_i,
    input  lsu_pkg::word_t     port_rdata_i,
    input  logic               port_rvalid_i,
    output logic               ready_o,
    output logic               resp_valid_o,
    output lsu_pkg::word_t     resp_data_o,
    output lsu_pkg::mem_req_t  port_req_o,
    output logic               port_valid_o,
    output logic               port_rready_o
);

    import lsu_pkg::*;

    port_state_t state_r;
    port_state_t state_ns;

    mem_req_t    port_req_r;
    mem_req_t    port_req_ns;
    logic        port_valid_r;
    logic        port_valid_ns;
    logic        port_rready_r;
    logic        port_rready_ns;

    // Kept for formatting the returned word
    size_t       ld_size_r;
    size_t       ld_size_ns;
    logic [1:0]  ld_offset_r;
    logic [1:0]  ld_offset_ns;

    word_t       st_data;
    bmask_t      st_mask;
    word_t       ld_data;

    lsu_align u_align (
        .st_data_i   (req_i.wdata),
        .st_size_i   (req_i.size),
        .st_offset_i (req_i.addr[1:0]),
        .ld_word_i   (port_rdata_i),
        .ld_size_i   (ld_size_r),
        .ld_offset_i (ld_offset_r),
        .st_data_o   (st_data),
        .st_mask_o   (st_mask),
        .ld_data_o   (ld_data)
    );

    always_comb begin
        state_ns       = state_r;
        port_req_ns    = port_req_r;
        port_valid_ns  = port_valid_r;
        port_rready_ns = port_rready_r;
        ld_size_ns     = ld_size_r;
        ld_offset_ns   = ld_offset_r;
        resp_valid_o   = 1'b0;
        resp_data_o    = '0;

        case (state_r)
            IDLE: begin
                if (req_valid_i) begin
                    port_req_ns.addr     = {req_i.addr[31:2], 2'b00};
                    port_req_ns.write    = req_i.write;
                    port_req_ns.uncached = uncached_i;
                    port_req_ns.wdata    = st_data;
                    port_req_ns.mask     = st_mask;
                    ld_size_ns           = req_i.size;
                    ld_offset_ns         = req_i.addr[1:0];
                    port_valid_ns        = 1'b1;
                    state_ns             = REQUEST;
                end
            end
            REQUEST: begin
                if (port_valid_r && port_ready_i) begin
                    port_valid_ns = 1'b0;
                    if (port_req_r.write) begin
                        // Store is done once the port takes it
                        resp_valid_o = 1'b1;
                        state_ns     = IDLE;
                    end else begin
                        port_rready_ns = 1'b1;
                        state_ns       = WAIT_DATA;
                    end
                end
            end
            WAIT_DATA: begin
                if (port_rvalid_i && port_rready_r) begin
                    port_rready_ns = 1'b0;
                    resp_valid_o   = 1'b1;
                    resp_data_o    = ld_data;
                    state_ns       = IDLE;
                end
            end
            default: begin
                state_ns = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_r       <= IDLE;
            port_valid_r  <= 1'b0;
            port_rready_r <= 1'b0;
        end else begin
            state_r       <= state_ns;
            port_valid_r  <= port_valid_ns;
            port_rready_r <= port_rready_ns;
        end
    end

    always_ff @(posedge clk_i) begin
        port_req_r  <= port_req_ns;
        ld_size_r   <= ld_size_ns;
        ld_offset_r <= ld_offset_ns;
    end

    assign ready_o       = state_r == IDLE;
    assign port_req_o    = port_req_r;
    assign port_valid_o  = port_valid_r;
    assign port_rready_o = port_rready_r;

endmodule

// ==== hdl/lsu_align.sv ====
`timescale 1ns/1ps

module lsu_align (
    input  lsu_pkg::word_t  st_data_i,
    input  lsu_pkg::size_t  st_size_i,
    input  logic [1:0]      st_offset_i,
    input  lsu_pkg::word_t  ld_word_i,
    input  lsu_pkg::size_t  ld_size_i,
    input  logic [1:0]      ld_offset_i,
    output lsu_pkg::word_t  st_data_o,
    output lsu_pkg::bmask_t st_mask_o,
    output lsu_pkg::word_t  ld_data_o
);

    import lsu_pkg::*;

    word_t ld_shift;

    // Store lanes, the byte or halfword is copied into every lane
    always_comb begin
        case (st_size_i)
            SIZE_B: begin
                st_data_o = {4{st_data_i[7:0]}};
                st_mask_o = 4'b0001 << st_offset_i;
            end
            SIZE_H: begin
                st_data_o = {2{st_data_i[15:0]}};
                st_mask_o = st_offset_i[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_data_o = st_data_i;
                st_mask_o = 4'b1111;
            end
        endcase
    end

    // Addressed byte moved down to lane 0
    assign ld_shift = ld_word_i >> {ld_offset_i, 3'b000};

    always_comb begin
        case (ld_size_i)
            SIZE_B: begin
                ld_data_o = {{24{ld_shift[7]}}, ld_shift[7:0]};
            end
            SIZE_BU: begin
                ld_data_o = {24'h00_0000, ld_shift[7:0]};
            end
            SIZE_H: begin
                ld_data_o = {{16{ld_shift[15]}}, ld_shift[15:0]};
            end
            SIZE_HU: begin
                ld_data_o = {16'h0000, ld_shift[15:0]};
            end
            default: begin
                ld_data_o = ld_word_i;
            end
        endcase
    end

endmodule

// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

    // Meaningful widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  bmask_t;

    // Access size in RV32 funct3 encoding
    typedef logic [2:0] size_t;

    localparam size_t SIZE_B  = 3'b000;
    localparam size_t SIZE_H  = 3'b001;
    localparam size_t SIZE_W  = 3'b010;
    localparam size_t SIZE_BU = 3'b100;
    localparam size_t SIZE_HU = 3'b101;

    typedef struct packed {
        logic  write;
        size_t size;
        addr_t addr;
        word_t wdata;
    } lsu_req_t;

    // Word-wide request on the memory port
    typedef struct packed {
        addr_t  addr;
        logic   write;
        logic   uncached;
        word_t  wdata;
        bmask_t mask;
    } mem_req_t;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT_DATA
    } port_state_t;

    localparam int RAM_WORDS  = 256;
    localparam int IO_WORDS   = 4;
    localparam int IO_WAIT    = 2;
    localparam int RAM_IDX_W  = $clog2(RAM_WORDS);
    localparam int IO_IDX_W   = $clog2(IO_WORDS);
    localparam int WAIT_CNT_W = $clog2(IO_WAIT + 1);

    // Cacheable window after reset, 1 KB at address zero
    localparam addr_t REGION_BASE_RST = 32'h0000_0000;
    localparam addr_t REGION_MASK_RST = 32'h0000_03FF;

endpackage
